/* tb.f */
+incdir+include
rtl/fe_pkg.sv
rtl/fe_if.sv
rtl/imem.sv
rtl/bht.sv
rtl/branch_filter.sv
rtl/pc_sequencer.sv
rtl/fetch_top.sv
tb/fe_model.sv
tb/tb_fetch.sv

/* tb/tb_fetch.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

module tb_fetch import fe_model::*; ();

   localparam int ACK_TMO = 20;

   logic                   clk;
   logic                   rst_n;
   logic                   imem_we;
   logic [`FE_IMEM_AW-1:0] imem_addr;
   logic [15:0]            imem_wdata;
   logic                   stall;
   logic                   commit_req;
   logic                   commit_ack;
   logic                   commit_mispred;
   logic                   commit_taken;
   logic [15:0]            commit_pc;
   logic [15:0]            commit_target;
   logic [15:0]            fetch_pc;
   logic [15:0]            slot0;
   logic [15:0]            slot1;
   logic [15:0]            slot2;
   logic [15:0]            slot3;
   logic [`FE_WIDTH-1:0]   taken_mask;

   // model side of the pipeline
   logic [15:0]                m_pc;
   logic                       m_acked;
   logic                       res_v;
   logic [`FE_WIDTH-1:0][15:0] exp_slots;
   logic [`FE_WIDTH-1:0]       exp_mask;
   logic [15:0]                exp_npc;
   int                         exp_add;

   int     slot_err;
   int     mask_err;
   int     pc_err;
   int     ack_err;
   int     tmo_err;
   integer seed;

   fetch_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .imem_we        (imem_we),
      .imem_addr      (imem_addr),
      .imem_wdata     (imem_wdata),
      .stall          (stall),
      .commit_req     (commit_req),
      .commit_ack     (commit_ack),
      .commit_mispred (commit_mispred),
      .commit_taken   (commit_taken),
      .commit_pc      (commit_pc),
      .commit_target  (commit_target),
      .fetch_pc       (fetch_pc),
      .slot0          (slot0),
      .slot1          (slot1),
      .slot2          (slot2),
      .slot3          (slot3),
      .taken_mask     (taken_mask)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   // expectations settle mid cycle, well away from both edges
   always @(negedge clk)
      eval_group(m_pc, stall, exp_slots, exp_mask, exp_npc, exp_add);

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reset_state();
         m_pc    <= `FE_RESET_PC;
         m_acked <= 1'b0;
      end else begin
         // accepted on the first req cycle with ack low
         res_v = commit_req && !m_acked;
         commit_update(res_v, commit_mispred, commit_taken, commit_pc, exp_add);
         m_pc    <= (res_v && commit_mispred) ? commit_target : exp_npc;
         // ack is req delayed by one edge
         m_acked <= commit_req;
      end
   end

   a_slots: assert property (@(posedge clk) disable iff (!rst_n)
      {slot3, slot2, slot1, slot0} == exp_slots)
   else begin
      slot_err++;
      $display("error: slot3..slot0 dut=%h exp=%h at %0t",
               $sampled({slot3, slot2, slot1, slot0}), $sampled(exp_slots), $time);
   end

   a_mask: assert property (@(posedge clk) disable iff (!rst_n)
      taken_mask == exp_mask)
   else begin
      mask_err++;
      $display("error: taken_mask dut=%h exp=%h at %0t",
               $sampled(taken_mask), $sampled(exp_mask), $time);
   end

   a_pc: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_pc == m_pc)
   else begin
      pc_err++;
      $display("error: fetch_pc dut=%h exp=%h at %0t",
               $sampled(fetch_pc), $sampled(m_pc), $time);
   end

   a_ack: assert property (@(posedge clk) disable iff (!rst_n)
      commit_ack == m_acked)
   else begin
      ack_err++;
      $display("error: commit_ack dut=%h exp=%h at %0t",
               $sampled(commit_ack), $sampled(m_acked), $time);
   end

   ////////////////////////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////////////////////////

   // inputs move 1 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   // fill pattern first, then the test program on top
   task automatic load_program();
      for (int a = 0; a < 256; a++)
         prog[a] = {8'h20, 8'(a)};
      // jump at 05 to 10
      prog[8'h05] = 16'hf00b;
      // branch at 11 to 24
      prog[8'h11] = 16'h9113;
      // three branches in one group
      prog[8'h24] = 16'ha240;
      prog[8'h25] = 16'hb340;
      prog[8'h26] = 16'h9440;
      // two branches behind the redirect target 08
      // skipped by the jump at 05, so never on the fall through path
      prog[8'h0a] = 16'h9510;
      prog[8'h0b] = 16'ha610;
      for (int a = 0; a < 256; a++) begin
         step();
         imem_we    = 1'b1;
         imem_addr  = 8'(a);
         imem_wdata = prog[a];
      end
      step();
      imem_we = 1'b0;
   endtask

   // one full four phase commit
   task automatic commit(input logic mis, input logic tk,
                         input logic [15:0] bpc, input logic [15:0] tgt);
      int n;
      commit_req     = 1'b1;
      commit_mispred = mis;
      commit_taken   = tk;
      commit_pc      = bpc;
      commit_target  = tgt;
      n = 0;
      while (!commit_ack && n < ACK_TMO) begin
         step();
         n++;
      end
      if (!commit_ack) begin
         tmo_err++;
         $display("timeout: commit_ack never rose for the commit at pc %h", bpc);
      end
      commit_req = 1'b0;
      n = 0;
      while (commit_ack && n < ACK_TMO) begin
         step();
         n++;
      end
      if (commit_ack) begin
         tmo_err++;
         $display("timeout: commit_ack stayed high after commit_req fell");
      end
      step();
   endtask

   // wait until the low pc byte reaches a given address
   task automatic wait_pc(input logic [7:0] want, input int limit);
      int n;
      n = 0;
      while (fetch_pc[7:0] != want && n < limit) begin
         step();
         n++;
      end
      if (fetch_pc[7:0] != want) begin
         tmo_err++;
         $display("timeout: fetch_pc never reached %h", want);
      end
   endtask

   task automatic stall_bursts();
      int len;
      int gap;
      for (int b = 0; b < 5; b++) begin
         len   = ($random(seed) & 3) + 1;
         gap   = ($random(seed) & 3) + 1;
         stall = 1'b1;
         repeat (len) step();
         stall = 1'b0;
         repeat (gap) step();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      seed           = 32'h6818_1a51;
      slot_err       = 0;
      mask_err       = 0;
      pc_err         = 0;
      ack_err        = 0;
      tmo_err        = 0;
      rst_n          = 1'b0;
      imem_we        = 1'b0;
      imem_addr      = '0;
      imem_wdata     = '0;
      stall          = 1'b0;
      commit_req     = 1'b0;
      commit_mispred = 1'b0;
      commit_taken   = 1'b0;
      commit_pc      = '0;
      commit_target  = '0;

      load_program();
      repeat (4) step();
      rst_n = 1'b1;

      // straight line, jump, weak branch at 11
      wait_pc(8'h14, 40);
      // first taken commit at 11, count back to zero before 24
      commit(1'b0, 1'b1, 16'h0011, 16'h0024);

      // three branches at 24, two kept, refetch from 26
      wait_pc(8'h26, 40);
      repeat (3) step();

      // finish training 11 and drain the count
      commit(1'b0, 1'b1, 16'h0011, 16'h0024);
      commit(1'b0, 1'b0, 16'h0024, 16'h0064);

      // stalls on the way round, then the taken branch to 24
      stall_bursts();
      wait_pc(8'h24, 300);
      repeat (3) step();

      // redirect clears the count, both branches at 0a and 0b kept
      commit(1'b1, 1'b1, 16'h0024, 16'h0008);
      wait_pc(8'h0c, 20);
      repeat (4) step();

      $display("errors: slots=%0d mask=%0d pc=%0d ack=%0d timeout=%0d",
               slot_err, mask_err, pc_err, ack_err, tmo_err);
      if (slot_err + mask_err + pc_err + ack_err + tmo_err == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/fe_model.sv */
`default_nettype none
`include "fe_params.svh"

package fe_model;

   // reference copy of imem contents
   logic [15:0] prog [256];

   // reference predictor counters, 01 out of reset
   logic [1:0]  ctr [16];

   // unresolved branches in flight
   int          cnt;

   function automatic void reset_state();
      for (int i = 0; i < 16; i++)
         ctr[i] = 2'b01;
      cnt = 0;
   endfunction

   ////////////////////////////////////////////////////////////
   // expected group for one fetch address
   ////////////////////////////////////////////////////////////

   function automatic void eval_group(
      input  logic [15:0]               pc,
      input  logic                      stall,
      output logic [`FE_WIDTH-1:0][15:0] slots,
      output logic [`FE_WIDTH-1:0]      mask,
      output logic [15:0]               npc,
      output int                        added
   );
      logic [15:0] a;
      logic [15:0] w;
      logic        br;
      logic        jp;
      logic        done;
      int          seen;
      slots = '0;
      mask  = '0;
      added = 0;
      seen  = cnt;
      // stalled or full: nothing leaves, pc stays
      done  = stall || (cnt >= `FE_MAX_BRANCH);
      npc   = done ? pc : pc + 16'd4;
      for (int i = 0; i < `FE_WIDTH; i++) begin
         if (!done) begin
            a  = pc + 16'(i);
            w  = prog[a[7:0]];
            // 10xx with xx nonzero
            br = (w[15:14] == 2'b10) && (w[13:12] != 2'b00);
            jp = (w[15:12] == 4'hf);
            if (br && seen >= `FE_MAX_BRANCH) begin
               // third unresolved branch, refetch it later
               done = 1'b1;
               npc  = a;
            end else begin
               slots[i] = w;
               if (br) begin
                  seen++;
                  added++;
                  if (ctr[a[3:0]][1]) begin
                     mask[i] = 1'b1;
                     done    = 1'b1;
                     npc     = a + {{8{w[7]}}, w[7:0]};
                  end
               end else if (jp) begin
                  done = 1'b1;
                  npc  = a + {{4{w[11]}}, w[11:0]};
               end
            end
         end
      end
   endfunction

   ////////////////////////////////////////////////////////////
   // end of cycle state update
   ////////////////////////////////////////////////////////////

   function automatic void commit_update(
      input logic        valid,
      input logic        mispred,
      input logic        taken,
      input logic [15:0] bpc,
      input int          added
   );
      if (valid) begin
         // saturating counter step
         if (taken && ctr[bpc[3:0]] != 2'b11)
            ctr[bpc[3:0]] = ctr[bpc[3:0]] + 2'b01;
         else if (!taken && ctr[bpc[3:0]] != 2'b00)
            ctr[bpc[3:0]] = ctr[bpc[3:0]] - 2'b01;
         // resolve wins over this cycle's group
         if (mispred)
            cnt = 0;
         else if (cnt > 0)
            cnt = cnt - 1;
      end else begin
         cnt = cnt + added;
         if (cnt > `FE_MAX_BRANCH)
            cnt = `FE_MAX_BRANCH;
      end
   endfunction

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

module fetch_top (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   imem_we,
   input  wire logic [`FE_IMEM_AW-1:0] imem_addr,
   input  wire logic [15:0]            imem_wdata,
   input  wire logic                   stall,
   input  wire logic                   commit_req,
   output logic                        commit_ack,
   input  wire logic                   commit_mispred,
   input  wire logic                   commit_taken,
   input  wire logic [15:0]            commit_pc,
   input  wire logic [15:0]            commit_target,
   output logic [15:0]                 fetch_pc,
   output logic [15:0]                 slot0,
   output logic [15:0]                 slot1,
   output logic [15:0]                 slot2,
   output logic [15:0]                 slot3,
   output logic [`FE_WIDTH-1:0]        taken_mask
);

   fetch_grp_if grp ();
   resolve_if   res ();

   // per slot predictions, bht -> filter
   logic [`FE_WIDTH-1:0] pred_taken;
   // filter's choice, before commit redirect
   logic [15:0]          next_pc;

   imem u_imem (
      .clk   (clk),
      .we    (imem_we),
      .waddr (imem_addr),
      .wdata (imem_wdata),
      .grp   (grp.mem)
   );

   bht u_bht (
      .clk        (clk),
      .rst_n      (rst_n),
      .grp        (grp.filt),
      .res        (res.listen),
      .pred_taken (pred_taken)
   );

   branch_filter u_filt (
      .clk        (clk),
      .rst_n      (rst_n),
      .grp        (grp.filt),
      .res        (res.listen),
      .pred_taken (pred_taken),
      .stall      (stall),
      .slot0      (slot0),
      .slot1      (slot1),
      .slot2      (slot2),
      .slot3      (slot3),
      .taken_mask (taken_mask),
      .next_pc    (next_pc)
   );

   pc_sequencer u_seq (
      .clk            (clk),
      .rst_n          (rst_n),
      .grp            (grp.seq),
      .res            (res.drive),
      .next_pc        (next_pc),
      .commit_req     (commit_req),
      .commit_ack     (commit_ack),
      .commit_mispred (commit_mispred),
      .commit_taken   (commit_taken),
      .commit_pc      (commit_pc),
      .commit_target  (commit_target)
   );

   assign fetch_pc = grp.pc;

endmodule

`default_nettype wire

/* rtl/pc_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

module pc_sequencer (
   input  wire logic        clk,
   input  wire logic        rst_n,
   fetch_grp_if.seq         grp,
   resolve_if.drive         res,
   input  wire logic [15:0] next_pc,
   input  wire logic        commit_req,
   output logic             commit_ack,
   input  wire logic        commit_mispred,
   input  wire logic        commit_taken,
   input  wire logic [15:0] commit_pc,
   input  wire logic [15:0] commit_target
);

   // handshake states
   localparam logic ST_IDLE  = 1'b0;
   localparam logic ST_ACKED = 1'b1;

   logic state;

   ////////////////////////////////////////////////////////////
   // four phase commit slave
   ////////////////////////////////////////////////////////////

   // idle -> acked on req, acked -> idle once req drops
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= ST_IDLE;
      else if (state == ST_IDLE && commit_req)
         state <= ST_ACKED;
      else if (state == ST_ACKED && !commit_req)
         state <= ST_IDLE;
   end

   assign commit_ack = (state == ST_ACKED);

   // single cycle pulse on acceptance
   // payload is held stable by the requester
   assign res.valid   = (state == ST_IDLE) && commit_req;
   assign res.mispred = commit_mispred;
   assign res.taken   = commit_taken;
   assign res.pc      = commit_pc;
   assign res.target  = commit_target;

   ////////////////////////////////////////////////////////////
   // fetch pc
   ////////////////////////////////////////////////////////////

   // mispredict redirect beats the filter's choice
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         grp.pc <= `FE_RESET_PC;
      else if (res.valid && res.mispred)
         grp.pc <= res.target;
      else
         grp.pc <= next_pc;
   end

   // requester raises a new req only once ack has dropped
   a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(commit_req) |-> !commit_ack);

endmodule

`default_nettype wire

/* rtl/branch_filter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

module branch_filter import fe_pkg::*; (
   input  wire logic               clk,
   input  wire logic               rst_n,
   fetch_grp_if.filt               grp,
   resolve_if.listen               res,
   input  wire logic [3:0]         pred_taken,
   input  wire logic               stall,
   output logic [15:0]             slot0,
   output logic [15:0]             slot1,
   output logic [15:0]             slot2,
   output logic [15:0]             slot3,
   output logic [3:0]              taken_mask,
   output logic [15:0]             next_pc
);

   localparam int W    = `FE_WIDTH;
   localparam int MAXB = `FE_MAX_BRANCH;
   localparam int CW   = $clog2(MAXB + 1);

   // per slot decode
   instr_u        ins     [W];
   logic [15:0]   slot_pc [W];
   logic [15:0]   tgt     [W];
   logic [W-1:0]  is_br;
   logic [W-1:0]  is_jmp;

   // scan results
   logic [W-1:0]  keep;
   logic [W-1:0]  tkn;
   logic [CW-1:0] br_add;
   logic [15:0]   redirect_pc;
   logic          hold;

   // in flight branches
   logic [CW-1:0] br_cnt;
   logic [CW-1:0] br_cnt_inc;
   logic [CW:0]   br_sum;

   logic [15:0]   out_word [W];

   ////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < W; i++) begin
         ins[i]     = grp.word[i];
         slot_pc[i] = grp.pc + 16'(i);
         is_br[i]   = is_branch(ins[i]);
         is_jmp[i]  = is_jump(ins[i]);
         tgt[i]     = slot_target(slot_pc[i], ins[i]);
      end
   end

   ////////////////////////////////////////////////////////////
   // cut scan
   ////////////////////////////////////////////////////////////

   // walk slots in order, stop at the first cut point
   always_comb begin
      logic          cut;
      logic [CW-1:0] seen;
      cut         = 1'b0;
      seen        = br_cnt;
      keep        = '0;
      tkn         = '0;
      br_add      = '0;
      redirect_pc = grp.pc + 16'(W);
      for (int i = 0; i < W; i++) begin
         if (!cut) begin
            if (is_br[i] && seen >= CW'(MAXB)) begin
               // would be a third unresolved branch
               // refetch from here once a commit frees a place
               cut         = 1'b1;
               redirect_pc = slot_pc[i];
            end else begin
               keep[i] = 1'b1;
               if (is_br[i]) begin
                  seen   = seen + 1'b1;
                  br_add = br_add + 1'b1;
                  if (pred_taken[i]) begin
                     tkn[i]      = 1'b1;
                     cut         = 1'b1;
                     redirect_pc = tgt[i];
                  end
               end else if (is_jmp[i]) begin
                  // jump stays, everything behind it goes
                  cut         = 1'b1;
                  redirect_pc = tgt[i];
               end
            end
         end
      end
   end

   // stalled or already at limit: whole group NOP, pc held
   assign hold = stall || (br_cnt >= CW'(MAXB));

   always_comb begin
      for (int i = 0; i < W; i++)
         out_word[i] = (keep[i] && !hold) ? grp.word[i] : NOP_WORD;
   end

   assign slot0      = out_word[0];
   assign slot1      = out_word[1];
   assign slot2      = out_word[2];
   assign slot3      = out_word[3];
   assign taken_mask = hold ? '0 : tkn;
   assign next_pc    = hold ? grp.pc : redirect_pc;

   ////////////////////////////////////////////////////////////
   // branch count
   ////////////////////////////////////////////////////////////

   // add kept branches, saturate at the limit
   assign br_sum     = {1'b0, br_cnt} + {1'b0, br_add};
   assign br_cnt_inc = (br_sum > (CW+1)'(MAXB)) ? CW'(MAXB) : br_sum[CW-1:0];

   // commits win over the group's own increment
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         br_cnt <= '0;
      end else if (res.valid && res.mispred) begin
         br_cnt <= '0;
      end else if (res.valid) begin
         if (br_cnt != '0)
            br_cnt <= br_cnt - 1'b1;
      end else if (!hold) begin
         br_cnt <= br_cnt_inc;
      end
   end

   a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
      br_cnt <= CW'(MAXB));

endmodule

`default_nettype wire

/* rtl/bht.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

module bht (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   fetch_grp_if.filt                 grp,
   resolve_if.listen                 res,
   output logic [`FE_WIDTH-1:0]      pred_taken
);

   localparam int BW      = `FE_BHT_AW;
   localparam int ENTRIES = 1 << BW;

   // 2-bit saturating counters
   // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
   logic [1:0] ctr [ENTRIES];

   logic [BW-1:0] upd_idx;

   ////////////////////////////////////////////////////////////
   // per slot lookup
   ////////////////////////////////////////////////////////////

   // index = low bits of each slot address
   for (genvar i = 0; i < `FE_WIDTH; i++) begin : g_rd
      logic [BW-1:0] ridx;
      assign ridx          = grp.pc[BW-1:0] + BW'(i);
      // msb of counter is the prediction
      assign pred_taken[i] = ctr[ridx][1];
   end

   ////////////////////////////////////////////////////////////
   // commit update
   ////////////////////////////////////////////////////////////

   assign upd_idx = res.pc[BW-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // everything starts weakly not taken
         for (int i = 0; i < ENTRIES; i++)
            ctr[i] <= 2'b01;
      end else if (res.valid) begin
         if (res.taken && ctr[upd_idx] != 2'b11)
            ctr[upd_idx] <= ctr[upd_idx] + 2'b01;
         else if (!res.taken && ctr[upd_idx] != 2'b00)
            ctr[upd_idx] <= ctr[upd_idx] - 2'b01;
      end
   end

   // handshake gives at most one update per commit
   a_one_update: assert property (@(posedge clk) disable iff (!rst_n)
      res.valid |=> !res.valid);

endmodule

`default_nettype wire

/* rtl/imem.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

module imem (
   input  wire logic                   clk,
   input  wire logic                   we,
   input  wire logic [`FE_IMEM_AW-1:0] waddr,
   input  wire logic [15:0]            wdata,
   fetch_grp_if.mem                    grp
);

   localparam int AW    = `FE_IMEM_AW;
   localparam int DEPTH = 1 << AW;

   // program storage, no reset
   logic [15:0] mem [DEPTH];

   // load port, only used while fetch sits in reset
   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   ////////////////////////////////////////////////////////////
   // group read
   ////////////////////////////////////////////////////////////

   // four words at pc .. pc+3
   // address sum is AW bits wide so the group wraps at the top
   for (genvar i = 0; i < `FE_WIDTH; i++) begin : g_rd
      logic [AW-1:0] raddr;
      assign raddr       = grp.pc[AW-1:0] + AW'(i);
      assign grp.word[i] = mem[raddr];
   end

endmodule

`default_nettype wire

/* rtl/fe_if.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fe_params.svh"

// fetch pc out, raw group back
interface fetch_grp_if;
   logic [15:0]                 pc;
   logic [`FE_WIDTH-1:0][15:0]  word;

   modport mem  (input pc, output word);
   modport seq  (output pc);
   modport filt (input pc, input word);
endinterface

// one cycle commit broadcast
interface resolve_if;
   logic        valid;
   logic        mispred;
   logic        taken;
   logic [15:0] pc;
   logic [15:0] target;

   modport drive  (output valid, output mispred, output taken, output pc, output target);
   modport listen (input valid, input mispred, input taken, input pc, input target);
endinterface

`default_nettype wire

/* rtl/fe_pkg.sv */
`default_nettype none

package fe_pkg;

   // conditional branch layout
   typedef struct packed {
      logic [3:0] opcode;
      logic [3:0] rs;
      logic [7:0] offset;
   } branch_fmt_t;

   // immediate jump layout
   typedef struct packed {
      logic [3:0]  opcode;
      logic [11:0] offset;
   } jump_fmt_t;

   // one instruction word, two views
   typedef union packed {
      branch_fmt_t branch_fmt;
      jump_fmt_t   jump_fmt;
   } instr_u;

   localparam logic [3:0]  OP_JUMP  = 4'b1111;
   localparam logic [15:0] NOP_WORD = 16'h0000;

   // opcode 10xx, xx not 00
   function automatic logic is_branch(instr_u ins);
      return (ins.branch_fmt.opcode[3:2] == 2'b10) &&
             (ins.branch_fmt.opcode[1:0] != 2'b00);
   endfunction

   function automatic logic is_jump(instr_u ins);
      return ins.jump_fmt.opcode == OP_JUMP;
   endfunction

   // slot address plus sign extended offset, wraps at 2^16
   function automatic logic [15:0] slot_target(logic [15:0] slot_pc, instr_u ins);
      logic [15:0] ofs;
      if (is_jump(ins))
         ofs = {{4{ins.jump_fmt.offset[11]}}, ins.jump_fmt.offset};
      else
         ofs = {{8{ins.branch_fmt.offset[7]}}, ins.branch_fmt.offset};
      return slot_pc + ofs;
   endfunction

endpackage

`default_nettype wire

/* include/fe_params.svh */
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// slots fetched per cycle
`define FE_WIDTH      4

// unresolved branches allowed in flight
`define FE_MAX_BRANCH 2

// imem address bits, 256 words
`define FE_IMEM_AW    8

// predictor index bits, 16 counters
`define FE_BHT_AW     4

// fetch address out of reset
`define FE_RESET_PC   16'h0000

`endif
